// File: logic/exec_unit.sv
/* Single-cycle execute and writeback. Register file is written at the same edge as wb,
   so operands need no bypass, only the count port forwards the result in flight */
`default_nettype none

module exec_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire ucode_pkg::instr_t    issue,
    input  wire ucode_pkg::reg_addr_t count_addr,
    output ucode_pkg::word_t        count_data,
    input  wire                     flags_hold_en,
    input  wire                     flags_restore,
    output ucode_pkg::wb_t          wb,
    output ucode_pkg::flags_t       flags
);
    import ucode_pkg::*;

    word_t       rf [16];
    opcode_t     op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    imm_t        imm;
    word_t       a;
    word_t       b;
    word_t       result;
    logic [32:0] sum;         // Bit 32 is carry out, or no-borrow for subtract
    logic        ov;
    logic        we;
    logic        set_flags;
    flags_t      alu_flags;
    flags_t      flags_next;  // Value flags take at this edge without a restore
    flags_t      held_q;      // Pre-multiply copy

    assign op  = issue[31:25];
    assign rd  = issue[24:21];
    assign rs1 = issue[20:17];
    assign rs2 = issue[16:13];
    assign imm = issue[15:0];

    assign a = rf[rs1];
    assign b = rf[rs2];

    // Multiplier read, forwards the word now in execute
    assign count_data = (we && rd == count_addr) ? result : rf[count_addr];

    always_comb begin
        sum       = 33'd0;
        ov        = 1'b0;
        we        = 1'b1;
        set_flags = 1'b0;
        result    = 32'd0;
        case (op)
            MOV_OP:  result = sext_imm(imm);
            ADD_OP, ADDS_OP: begin
                sum       = {1'b0, a} + {1'b0, b};
                result    = sum[31:0];
                ov        = (a[31] == b[31]) && (result[31] != a[31]);
                set_flags = (op == ADDS_OP);
            end
            SUB_OP, SUBS_OP: begin
                sum       = {1'b0, a} + {1'b0, ~b} + 33'd1;
                result    = sum[31:0];
                ov        = (a[31] != b[31]) && (result[31] != a[31]);
                set_flags = (op == SUBS_OP);
            end
            SUBI_OP: result = a - sext_imm(imm);
            NOT_OP:  result = ~a;
            default: we = 1'b0;   // NOP and anything unknown
        endcase

        alu_flags[FLAG_N] = result[31];
        alu_flags[FLAG_Z] = (result == 32'd0);
        alu_flags[FLAG_C] = sum[32];
        alu_flags[FLAG_V] = ov;
        flags_next        = set_flags ? alu_flags : flags;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            rf[rd] <= result;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags  <= 4'd0;
            held_q <= 4'd0;
            wb     <= '0;
        end else begin
            // Restore beats the SUBS of a plain zero-immediate clear
            flags <= flags_restore ? held_q : flags_next;
            if (flags_hold_en) begin
                held_q <= flags_next;   // Includes the word retiring at this edge
            end
            wb.valid <= we;
            wb.addr  <= rd;
            wb.data  <= result;
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
/* Issue register in front of execute. Sequencer words win over fetch words,
   although the decoder never lets both be valid in the same cycle */
`default_nettype none

module issue_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  mux_ctrl,
    input  wire ucode_pkg::instr_t uinstr,
    input  wire                  pass_valid,
    input  wire ucode_pkg::instr_t pass_instr,
    output ucode_pkg::instr_t    issue
);
    import ucode_pkg::*;

    instr_t issue_d;   // Word to present to execute next cycle

    // Source select
    always_comb begin
        if (mux_ctrl) begin
            issue_d = uinstr;        // Burst owns the slot
        end else if (pass_valid) begin
            issue_d = pass_instr;    // Plain word from fetch
        end else begin
            issue_d = NOP_WORD;      // Bubble, no writeback
        end
    end

    // Resets to a bubble so execute writes nothing while the pipe fills
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue <= NOP_WORD;
        end else begin
            issue <= issue_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/mul_decoder.sv
/* Multiply intercept. Multiplier register is read the cycle after acceptance, so the
   word ahead of it has reached execute and is forwarded by the count port */
`default_nettype none

module mul_decoder (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  instr_valid,
    input  wire ucode_pkg::instr_t instr,
    input  wire                  mul_release,
    input  wire ucode_pkg::word_t  count_data,
    output ucode_pkg::reg_addr_t count_addr,
    output logic                 ready,
    output logic                 start_mul,
    output ucode_pkg::mul_req_t  req,
    output logic                 pass_valid,
    output ucode_pkg::instr_t    pass_instr
);
    import ucode_pkg::*;

    logic      run_q;        // Goes high on the first edge out of reset
    logic      busy_q;       // Burst running, fetch held off
    logic      accept;
    logic      is_mul;
    logic      reg_form;
    mul_kind_e kind;
    logic      reg_form_q;   // Multiplier lives in rs2
    imm_t      imm_q;
    reg_addr_t rs2_q;
    word_t     mult_val;     // Signed multiplier, valid during the MOV cycle

    assign ready     = run_q & ~busy_q;
    assign accept    = instr_valid & ready;
    assign start_mul = accept & is_mul;
    assign reg_form  = (kind == MULR) || (kind == MULSR);

    always_comb begin
        is_mul = 1'b1;
        kind   = MULI;
        case (instr[31:25])
            MULI_OP:  kind = MULI;
            MULR_OP:  kind = MULR;
            MULSI_OP: kind = MULSI;
            MULSR_OP: kind = MULSR;
            default:  is_mul = 1'b0;   // Plain word, goes straight to issue
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q      <= 1'b0;
            busy_q     <= 1'b0;
            pass_valid <= 1'b0;
        end else begin
            run_q      <= 1'b1;
            pass_valid <= accept & ~is_mul;
            if (start_mul) begin
                busy_q <= 1'b1;
            end else if (mul_release) begin
                busy_q <= 1'b0;          // ready back one cycle after release
            end
        end
    end

    always_ff @(posedge clk) begin
        pass_instr <= instr;
        if (start_mul) begin
            reg_form_q <= reg_form;
            imm_q      <= instr[15:0];
            rs2_q      <= instr[16:13];
        end
    end

    assign count_addr = rs2_q;
    assign mult_val   = reg_form_q ? count_data : sext_imm(imm_q);

    always_comb begin
        req.kind      = kind;
        req.dest      = instr[24:21];
        req.source    = instr[20:17];
        req.zero_imm  = ~reg_form & (instr[15:0] == 16'd0);
        req.negate    = mult_val[31];
        req.magnitude = mult_val[31] ? (~mult_val + 32'd1) : mult_val;   // Two's complement
    end

endmodule

`default_nettype wire

// File: logic/mul_expand_top.sv
/* Datapath top. Source must hold a word until ready is high, one word per cycle at most */
`default_nettype none

module mul_expand_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  instr_valid,
    input  wire ucode_pkg::instr_t instr,
    output logic                 ready,
    output ucode_pkg::wb_t       wb,
    output ucode_pkg::flags_t    flags
);
    import ucode_pkg::*;

    logic      start_mul;
    mul_req_t  req;
    logic      pass_valid;
    instr_t    pass_instr;
    logic      mux_ctrl;
    instr_t    uinstr;
    logic      flags_hold_en;
    logic      flags_restore;
    logic      mul_release;
    instr_t    issue;
    reg_addr_t count_addr;
    word_t     count_data;

    mul_decoder u_dec (
        .clk, .rst, .instr_valid, .instr, .mul_release, .count_data,
        .count_addr, .ready, .start_mul, .req, .pass_valid, .pass_instr
    );

    ucode_sequencer u_seq (
        .clk, .rst, .start_mul, .req,
        .mux_ctrl, .uinstr, .flags_hold_en, .flags_restore, .mul_release
    );

    issue_stage u_issue (
        .clk, .rst, .mux_ctrl, .uinstr, .pass_valid, .pass_instr, .issue
    );

    exec_unit u_exec (
        .clk, .rst, .issue, .count_addr, .count_data,
        .flags_hold_en, .flags_restore, .wb, .flags
    );

endmodule

`default_nettype wire

// File: logic/ucode_pkg.sv
/* Shared types, opcodes and encoders for the multiply-expansion datapath.
   Immediate forms reuse bits [15:0], so rs2 [16:13] is not usable in an immediate word */
`default_nettype none

package ucode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;     // op[31:25] rd[24:21] rs1[20:17] rs2[16:13] / imm[15:0]
    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  flags_t;     // {N, Z, C, V}
    typedef logic [6:0]  opcode_t;

    // Bit positions inside flags_t
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Micro-op opcodes understood by the execute stage
    localparam opcode_t MOV_OP  = 7'b0000000;   // Rd = sext(imm)
    localparam opcode_t ADD_OP  = 7'b0110001;
    localparam opcode_t SUB_OP  = 7'b0110010;
    localparam opcode_t SUBI_OP = 7'b0010010;   // Rd = Rs1 - sext(imm)
    localparam opcode_t SUBS_OP = 7'b0111010;   // Sets NZCV
    localparam opcode_t ADDS_OP = 7'b0111001;   // Sets NZCV
    localparam opcode_t NOT_OP  = 7'b0110110;

    // Multiply forms caught by the decoder, never reach execute
    localparam opcode_t MULI_OP  = 7'b1010000;
    localparam opcode_t MULR_OP  = 7'b1010001;
    localparam opcode_t MULSI_OP = 7'b1011000;
    localparam opcode_t MULSR_OP = 7'b1011001;

    localparam instr_t NOP_WORD = {5'b11001, 27'b0};   // Opcode outside the ALU subset

    typedef enum logic [1:0] {MULI, MULR, MULSI, MULSR} mul_kind_e;

    typedef enum logic [2:0] {
        S_IDLE, S_CLEAR, S_MOV, S_ADD, S_FIX_SUB, S_FIX_NOT, S_HALT
    } seq_state_e;

    // kind/dest/source/zero_imm valid with start_mul, magnitude/negate one cycle later
    typedef struct packed {
        mul_kind_e kind;
        reg_addr_t dest;
        reg_addr_t source;
        word_t     magnitude;
        logic      negate;
        logic      zero_imm;
    } mul_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    function automatic instr_t enc_rrr(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                       reg_addr_t rs2);
        return {op, rd, rs1, rs2, 13'b0};
    endfunction

    function automatic instr_t enc_ri(opcode_t op, reg_addr_t rd, reg_addr_t rs1, imm_t imm);
        return {op, rd, rs1, 1'b0, imm};
    endfunction

    function automatic word_t sext_imm(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

`default_nettype wire

// File: logic/ucode_sequencer.sv
/* Multiply burst FSM, one micro-op per cycle, cost grows with |multiplier|.
   Rd must differ from both source registers, and -2^31 is not a usable multiplier */
`default_nettype none

module ucode_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start_mul,
    input  wire ucode_pkg::mul_req_t req,
    output logic                   mux_ctrl,
    output ucode_pkg::instr_t      uinstr,
    output logic                   flags_hold_en,
    output logic                   flags_restore,
    output logic                   mul_release
);
    import ucode_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    mul_kind_e  kind_q;
    reg_addr_t  dest_q;
    reg_addr_t  src_q;
    word_t      count_q;     // ADDs still to emit
    logic       negate_q;    // Append SUBI/NOT fix
    logic       flag_set;    // S forms

    assign flag_set = (kind_q == MULSI) || (kind_q == MULSR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_mul) begin
            kind_q <= req.kind;
            dest_q <= req.dest;
            src_q  <= req.source;
        end
        if (state_q == S_MOV) begin
            // Magnitude only settles once the multiplier register is read
            count_q  <= req.magnitude;
            negate_q <= req.negate;
        end else if (state_q == S_ADD) begin
            count_q <= count_q - 32'd1;
        end
    end

    always_comb begin
        state_d       = state_q;
        mux_ctrl      = 1'b0;
        uinstr        = NOP_WORD;
        flags_hold_en = 1'b0;
        flags_restore = 1'b0;
        mul_release   = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (start_mul) begin
                    state_d = req.zero_imm ? S_CLEAR : S_MOV;
                end
            end

            // x * #0, single SUBS Rd,Rd,Rd
            S_CLEAR: begin
                mux_ctrl      = 1'b1;
                uinstr        = enc_rrr(SUBS_OP, dest_q, dest_q, dest_q);
                flags_hold_en = 1'b1;   // Snapshot before SUBS touches NZCV
                state_d       = S_HALT;
            end

            S_MOV: begin
                mux_ctrl      = 1'b1;
                uinstr        = enc_ri(MOV_OP, dest_q, 4'd0, 16'd0);   // Rd = 0
                flags_hold_en = 1'b1;
                if (req.magnitude == 32'd0) begin
                    state_d = S_HALT;   // Zero register multiplier, MOV is enough
                end else begin
                    state_d = S_ADD;
                end
            end

            // Rd += Rs once per unit of magnitude
            S_ADD: begin
                mux_ctrl = 1'b1;
                uinstr   = enc_rrr(flag_set ? ADDS_OP : ADD_OP, dest_q, dest_q, src_q);
                if (count_q == 32'd1) begin
                    if (negate_q) begin
                        state_d = S_FIX_SUB;
                    end else begin
                        state_d = S_HALT;
                    end
                end
            end

            // -x = ~(x - 1)
            S_FIX_SUB: begin
                mux_ctrl = 1'b1;
                uinstr   = enc_ri(SUBI_OP, dest_q, dest_q, 16'd1);
                state_d  = S_FIX_NOT;
            end

            S_FIX_NOT: begin
                mux_ctrl = 1'b1;
                uinstr   = enc_rrr(NOT_OP, dest_q, dest_q, 4'd0);
                state_d  = S_HALT;
            end

            // Last micro-op in execute now, restore lands with its writeback
            S_HALT: begin
                mul_release   = 1'b1;
                flags_restore = ~flag_set;   // Plain forms hide their own flag effects
                state_d       = S_IDLE;
            end

            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mul_expand_top.f
logic/ucode_pkg.sv
logic/mul_decoder.sv
logic/ucode_sequencer.sv
logic/issue_stage.sv
logic/exec_unit.sv
logic/mul_expand_top.sv
verif/tb_mul_expand.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mul_expand \
    -f mul_expand_top.f \
    --Mdir obj_dir -o tb_mul_expand

./obj_dir/tb_mul_expand

// File: verif/mul_expand_golden.txt
# name kind rd rs rm src mult product flags wbs (kind 0 MULI 1 MULR 2 MULSI 3 MULSR)
# src and mult are 16-bit hex, loaded by MOV or used as the immediate, flags are NZCV hex
muli_pos          0   1   2   0   0007  0003  00000015  0  4
mulsi_neg_src     2   3   4   0   fffb  0004  ffffffec  a  5
muli_keep_flags   0   5   6   0   0100  0002  00000200  a  3
muli_neg_imm      0   7   8   0   0006  fffd  ffffffee  a  6
muli_zero_imm     0   1  10   0   1234  0000  00000000  a  1
mulsi_zero_imm    2   3   4   0   0005  0000  00000000  6  1
mulsi_neg_imm     2  11  12   0   0009  fffe  ffffffee  0  5
mulr_neg_reg      1   9  10  11   0004  fffb  ffffffec  0  8
mulsr_zero_src    3  12  13  14   0000  0002  00000000  4  3
mulr_zero_reg     1   2   5   6   0003  0000  00000000  4  1
mulsr_neg_reg     3   7   8  13   fff8  fffd  00000018  a  6
muli_neg_src      0   4   1   0   ffff  0005  fffffffb  a  6
mulsr_pos         3  14   2   3   0011  0004  00000044  0  5
mulr_pos          1   0   6   7   0020  0006  000000c0  0  7

// File: verif/tb_mul_expand.sv
/* Runs the tests of verif/mul_expand_golden.txt from the project root. Rd of a test must
   differ from its sources and from R15, which takes the ADD that follows each multiply */
`default_nettype none

module tb_mul_expand;
    timeunit 1ns;
    timeprecision 100ps;
    import ucode_pkg::*;

    localparam int MAX_TESTS    = 32;
    localparam int RESET_CYCLES = 8;

    logic   clk;
    logic   rst;
    logic   instr_valid;
    instr_t instr;
    logic   ready;
    wb_t    wb;
    flags_t flags;

    // One golden line per test
    logic [8*24-1:0] t_name  [MAX_TESTS];
    int              t_kind  [MAX_TESTS];   // mul_kind_e order
    reg_addr_t       t_rd    [MAX_TESTS];
    reg_addr_t       t_rs    [MAX_TESTS];
    reg_addr_t       t_rm    [MAX_TESTS];   // Multiplier register of the register forms
    imm_t            t_src   [MAX_TESTS];
    imm_t            t_mult  [MAX_TESTS];
    word_t           t_prod  [MAX_TESTS];
    flags_t          t_flags [MAX_TESTS];
    int              t_wbs   [MAX_TESTS];
    int              n_tests;

    logic [31:0] lfsr = 32'ha24c38aa;
    int          cycles = 0;
    int          cycle_limit;
    int          wb_count [16] = '{default: 0};   // Writebacks seen per register
    word_t       wb_last  [16] = '{default: '0};  // Last value written per register

    mul_expand_top UUT (.clk, .rst, .instr_valid, .instr, .ready, .wb, .flags);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit set from the golden file at time 0
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    // Writeback monitor on the falling edge
    always @(negedge clk) begin
        if (wb.valid === 1'b1) begin
            wb_count[wb.addr] = wb_count[wb.addr] + 1;
            wb_last[wb.addr]  = wb.data;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Taps 32 22 2 1
    endfunction

    function automatic opcode_t mul_opcode(input int kind);
        case (kind)
            1:       return MULR_OP;
            2:       return MULSI_OP;
            3:       return MULSR_OP;
            default: return MULI_OP;
        endcase
    endfunction

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;   // Inputs change just after the edge
    endtask

    task automatic check_word(input int idx, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("mismatch %0s %0s: expected %h, actual %h", t_name[idx], what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flags(input int idx, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            $display("mismatch %0s flags: expected %b, actual %b", t_name[idx], exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input int idx, input string what, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %0s %0s: expected %0d, actual %0d", t_name[idx], what, exp, act);
            stop_run();
        end
    endtask

    // Comment and blank lines parse short and are skipped
    task automatic load_golden();
        int               fd;
        int               got;
        logic [8*160-1:0] text;
        n_tests = 0;
        fd = $fopen("verif/mul_expand_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/mul_expand_golden.txt");
            stop_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (n_tests >= MAX_TESTS) begin
                $display("golden file holds more than %0d tests", MAX_TESTS);
                stop_run();
            end
            got = $sscanf(text, "%s %d %d %d %d %h %h %h %h %d", t_name[n_tests],
                          t_kind[n_tests], t_rd[n_tests], t_rs[n_tests], t_rm[n_tests],
                          t_src[n_tests], t_mult[n_tests], t_prod[n_tests],
                          t_flags[n_tests], t_wbs[n_tests]);
            if (got == 10) begin
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("golden file holds no tests");
            stop_run();
        end
    endtask

    // Up to 3 idle cycles from two LFSR bits before the word goes out on ready
    task automatic send_word(input instr_t w, input logic with_gap);
        int gap;
        gap = 0;
        if (with_gap) begin
            repeat (2) begin
                gap  = (gap << 1) | int'(lfsr[0]);
                lfsr = lfsr_next(lfsr);
            end
        end
        repeat (gap) next_cycle();
        while (ready !== 1'b1) next_cycle();
        instr_valid = 1'b1;
        instr       = w;
        next_cycle();   // Taken at this edge
        instr_valid = 1'b0;
    endtask

    initial begin
        int     mag;
        int     ready_low;
        int     base_rd;
        int     base_fu;
        instr_t op_word;
        logic   op_gap;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = NOP_WORD;
        load_golden();
        cycle_limit = RESET_CYCLES;
        for (int i = 0; i < n_tests; i++) begin
            mag = int'($signed(t_mult[i]));
            if (mag < 0) begin
                mag = -mag;
            end
            cycle_limit += (mag + 8) * 4;   // Bursts grow one cycle per unit
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        if (ready !== 1'b0 || wb.valid !== 1'b0) begin
            $display("ready or wb.valid was high during reset");
            stop_run();
        end
        rst = 1'b0;
        next_cycle();
        if (ready !== 1'b1) begin
            $display("ready did not rise after reset");
            stop_run();
        end

        for (int i = 0; i < n_tests; i++) begin
            // Operand setup through plain MOVs
            send_word(enc_ri(MOV_OP, t_rs[i], 4'd0, t_src[i]), 1'b1);
            if (t_kind[i] == 1 || t_kind[i] == 3) begin
                send_word(enc_ri(MOV_OP, t_rm[i], 4'd0, t_mult[i]), 1'b1);
                op_word = enc_rrr(mul_opcode(t_kind[i]), t_rd[i], t_rs[i], t_rm[i]);
                op_gap  = 1'b0;   // Multiplier still in execute when the decoder reads it
            end else begin
                op_word = enc_ri(mul_opcode(t_kind[i]), t_rd[i], t_rs[i], t_mult[i]);
                op_gap  = 1'b1;
            end
            base_rd = wb_count[t_rd[i]];
            send_word(op_word, op_gap);
            ready_low = 0;
            while (ready !== 1'b1) begin   // Burst plus release cycle
                ready_low++;
                next_cycle();
            end
            // Back to back ADD reads the product just written
            base_fu = wb_count[15];
            send_word(enc_rrr(ADD_OP, 4'd15, t_rd[i], t_rd[i]), 1'b0);
            while (wb_count[15] == base_fu) next_cycle();

            check_count(i, "writebacks", t_wbs[i], wb_count[t_rd[i]] - base_rd);
            check_count(i, "ready low cycles", t_wbs[i] + 1, ready_low);
            check_word(i, "product", t_prod[i], wb_last[t_rd[i]]);
            check_flags(i, t_flags[i], flags);
            check_word(i, "follow-up add", t_prod[i] + t_prod[i], wb_last[15]);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
